//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_mem_subsystem
RTL_TOP   := mem_subsystem_top
FILELIST  := build.f
SIM       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- build.f
+incdir+common
common/mem_if_pkg.sv
logic/bank_grant_timer.sv
logic/banked_ram.sv
cpu_memory_interface/mem_arbiter_fsm.sv
cpu_memory_interface/mem_request_pipe.sv
cpu_memory_interface/cpu_memory_interface.sv
logic/mem_subsystem_top.sv
tb/tb_mem_subsystem.sv

//--- common/mem_if_config.svh
// Build-time sizes of the memory subsystem
//   word and address widths
//   bank grant delay
//   depth of each RAM bank
`ifndef MEM_IF_CONFIG_SVH
`define MEM_IF_CONFIG_SVH

// Data word width
`define MEM_BITS 16

// Word address width, top bit picks the bank
`define MEM_ADDRESS_BITS 15

// Cycles from valid rising to rdy
`define BANK_GRANT_CYCLES 3

// Words per bank, half the address space
`define RAM_BANK_WORDS (1 << (`MEM_ADDRESS_BITS - 1))

`endif

//--- common/mem_if_pkg.sv
// Shared types of the memory interface
//   address and word types
//   data path request, pipeline stage and memory bus structs
//   arbiter state encoding
`default_nettype none
`include "mem_if_config.svh"

package mem_if_pkg;

	typedef logic [`MEM_ADDRESS_BITS-1:0] addr_t;
	typedef logic [`MEM_BITS-1:0] word_t;

	// Request from the data path
	typedef struct packed {
		addr_t      addr;
		word_t      wdata;
		logic       rd_req;
		logic       wr_req;
		logic [1:0] wr_mask;
	} data_req_t;

	// One pipeline stage entry
	typedef struct packed {
		addr_t      addr;
		word_t      wdata;
		logic [1:0] wr_mask;
		logic       is_read;
		logic       is_instr;
		logic       is_req;
	} stage_req_t;

	// Command to the RAM
	typedef struct packed {
		addr_t      addr;
		word_t      wdata;
		logic [1:0] wr_mask;
		logic       wr;
	} mem_bus_t;

	typedef enum logic [1:0] {
		st_idle,
		st_request_bank,
		st_execute,
		st_bank_switch
	} arb_state_e;

endpackage

`default_nettype wire

//--- cpu_memory_interface/cpu_memory_interface.sv
// Memory interface between CPU fetch/data paths and banked memory
//   arbiter state machine instance
//   request pipeline instance
//   read data fan-out to both channels
`timescale 1ns/100ps
`default_nettype none

module cpu_memory_interface (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  mem_if_pkg::addr_t     instr_addr,
	input  logic                  instr_read_req,
	output mem_if_pkg::word_t     instr_data,
	output mem_if_pkg::addr_t     instr_addr_out,
	output logic                  instr_success,
	output logic                  instr_will_queue,
	input  mem_if_pkg::data_req_t data_req,
	output mem_if_pkg::word_t     data_rdata,
	output logic                  data_success,
	output logic                  data_was_requested,
	output logic [1:0]            data_wr_mask_out,
	input  logic                  halt,
	output logic                  bank_sw,
	output mem_if_pkg::mem_bus_t  mem_bus,
	input  mem_if_pkg::word_t     mem_rdata,
	output logic                  valid,
	input  logic                  rdy
);
	import mem_if_pkg::*;

	arb_state_e state;
	logic       exec_cycle;
	logic       capture_flags;
	logic       replay;
	logic       in_execute;
	logic       any_req;
	logic       bank_switch_required;

	// Success and writes only while the bank is held
	assign in_execute = (state == st_execute);

	// Memory data goes to both channels, success says which one is valid
	assign instr_data = mem_rdata;
	assign data_rdata = mem_rdata;

	mem_arbiter_fsm u_fsm (
		.CLK                  (CLK),
		.RSTb                 (RSTb),
		.any_req              (any_req),
		.rdy                  (rdy),
		.halt                 (halt),
		.bank_switch_required (bank_switch_required),
		.state                (state),
		.exec_cycle           (exec_cycle),
		.capture_flags        (capture_flags),
		.replay               (replay),
		.bank_sw              (bank_sw),
		.valid                (valid)
	);

	mem_request_pipe u_pipe (
		.CLK                  (CLK),
		.RSTb                 (RSTb),
		.instr_addr           (instr_addr),
		.instr_read_req       (instr_read_req),
		.data_req             (data_req),
		.exec_cycle           (exec_cycle),
		.capture_flags        (capture_flags),
		.replay               (replay),
		.in_execute           (in_execute),
		.mem_bus              (mem_bus),
		.any_req              (any_req),
		.bank_switch_required (bank_switch_required),
		.instr_addr_out       (instr_addr_out),
		.instr_success        (instr_success),
		.instr_will_queue     (instr_will_queue),
		.data_success         (data_success),
		.data_was_requested   (data_was_requested),
		.data_wr_mask_out     (data_wr_mask_out)
	);

endmodule

`default_nettype wire

//--- cpu_memory_interface/mem_arbiter_fsm.sv
// Bank arbiter state machine
//   idle, request bank, execute and bank switch states
//   valid and bank_sw decoded from the state
//   load, capture and replay controls for the request pipeline
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter_fsm (
	input  logic                   CLK,
	input  logic                   RSTb,
	input  logic                   any_req,
	input  logic                   rdy,
	input  logic                   halt,
	input  logic                   bank_switch_required,
	output mem_if_pkg::arb_state_e state,
	output logic                   exec_cycle,
	output logic                   capture_flags,
	output logic                   replay,
	output logic                   bank_sw,
	output logic                   valid
);
	import mem_if_pkg::*;

	arb_state_e next_state;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		unique case (state)
			// Wait for any channel to ask
			st_idle: begin
				if (any_req) begin
					next_state = st_request_bank;
				end
			end
			// Hold valid until the owner grants
			st_request_bank: begin
				if (rdy) begin
					next_state = st_execute;
				end
			end
			st_execute: begin
				if (bank_switch_required) begin
					next_state = st_bank_switch;
				end else if (!any_req && halt) begin
					// Nothing pending, park
					next_state = st_idle;
				end
			end
			// One cycle with the bank released, then ask again
			st_bank_switch: begin
				next_state = st_request_bank;
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	// New requests enter stage 1 only in a clean execute cycle
	assign exec_cycle = (state == st_execute) && !bank_switch_required;
	// Stage 2 hit a bank change, push it back into stage 1
	assign replay = (state == st_execute) && bank_switch_required;
	// Outside execute, stage 1 tracks the held data request
	assign capture_flags = (state != st_execute);

	assign bank_sw = (state == st_bank_switch) || (state == st_request_bank);
	assign valid = (state == st_request_bank) || (state == st_execute);

endmodule

`default_nettype wire

//--- cpu_memory_interface/mem_request_pipe.sv
// Two-stage request pipeline of the memory interface
//   data over instruction request selection
//   stage 1 (drives memory) and stage 2 (reports success)
//   registered bank change detection between stages
//   per-channel success and gated write strobe
`timescale 1ns/100ps
`default_nettype none
`include "mem_if_config.svh"

module mem_request_pipe (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  mem_if_pkg::addr_t     instr_addr,
	input  logic                  instr_read_req,
	input  mem_if_pkg::data_req_t data_req,
	input  logic                  exec_cycle,
	input  logic                  capture_flags,
	input  logic                  replay,
	input  logic                  in_execute,
	output mem_if_pkg::mem_bus_t  mem_bus,
	output logic                  any_req,
	output logic                  bank_switch_required,
	output mem_if_pkg::addr_t     instr_addr_out,
	output logic                  instr_success,
	output logic                  instr_will_queue,
	output logic                  data_success,
	output logic                  data_was_requested,
	output logic [1:0]            data_wr_mask_out
);
	import mem_if_pkg::*;

	localparam int BANK_BIT = `MEM_ADDRESS_BITS - 1;

	stage_req_t stage_1;
	stage_req_t stage_1_next;
	stage_req_t stage_2;
	stage_req_t data_entry;
	stage_req_t instr_entry;
	logic       data_active;
	logic       ok_to_complete;

	assign data_active = data_req.rd_req || data_req.wr_req;
	assign any_req = data_active || instr_read_req;

	// Candidate entries for stage 1
	always_comb begin
		data_entry.addr     = data_req.addr;
		data_entry.wdata    = data_req.wdata;
		data_entry.wr_mask  = data_req.wr_mask;
		data_entry.is_read  = data_req.rd_req;
		data_entry.is_instr = 1'b0;
		data_entry.is_req   = 1'b1;

		// Instruction fetch is always a full-word read
		instr_entry.addr     = instr_addr;
		instr_entry.wdata    = '0;
		instr_entry.wr_mask  = 2'b00;
		instr_entry.is_read  = 1'b1;
		instr_entry.is_instr = 1'b1;
		instr_entry.is_req   = 1'b1;
	end

	always_comb begin
		stage_1_next = stage_1;
		instr_will_queue = 1'b0;
		if (replay) begin
			// Retry the failed stage as a read, CPU repeats any write
			stage_1_next = stage_2;
			stage_1_next.is_read = 1'b1;
		end else if (exec_cycle) begin
			if (data_active) begin
				stage_1_next = data_entry;
			end else if (instr_read_req) begin
				stage_1_next = instr_entry;
				instr_will_queue = 1'b1;
			end else begin
				// Bubble
				stage_1_next = '0;
			end
		end else if (capture_flags && data_active) begin
			// Keep stage 1 on the held data request while waiting for the bank
			stage_1_next = data_entry;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stage_1 <= '0;
			stage_2 <= '0;
			bank_switch_required <= 1'b0;
		end else begin
			stage_1 <= stage_1_next;
			// Stage 2 always advances
			stage_2 <= stage_1;
			// Flags the entry now moving into stage 2
			bank_switch_required <= stage_1.addr[BANK_BIT] != stage_2.addr[BANK_BIT];
		end
	end

	assign ok_to_complete = in_execute && !bank_switch_required;

	// Stage 1 drives the memory
	assign mem_bus.addr    = stage_1.addr;
	assign mem_bus.wdata   = stage_1.wdata;
	assign mem_bus.wr_mask = stage_1.wr_mask;
	assign mem_bus.wr      = ok_to_complete && stage_1.is_req && !stage_1.is_read &&
		!stage_1.is_instr;

	// Stage 2 reports back
	assign instr_success      = ok_to_complete && stage_2.is_req && stage_2.is_instr;
	assign data_success       = ok_to_complete && stage_2.is_req && !stage_2.is_instr;
	assign data_was_requested = stage_2.is_req && !stage_2.is_instr;
	assign data_wr_mask_out   = stage_2.wr_mask;
	assign instr_addr_out     = stage_2.addr;

endmodule

`default_nettype wire

//--- logic/bank_grant_timer.sv
// Stand-in for the bank owner
//   counts cycles while valid is held
//   grants rdy after GRANT_CYCLES, restarts when valid drops
`timescale 1ns/100ps
`default_nettype none
`include "mem_if_config.svh"

module bank_grant_timer #(
	parameter int GRANT_CYCLES = `BANK_GRANT_CYCLES
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic valid,
	output logic rdy
);
	localparam int CNT_W = $clog2(GRANT_CYCLES + 1);

	logic [CNT_W-1:0] count;
	logic             count_done;

	assign count_done = (count == CNT_W'(GRANT_CYCLES));

	always_ff @(posedge CLK) begin
		if (!RSTb || !valid) begin
			// Every new request pays the full delay
			count <= '0;
		end else if (!count_done) begin
			count <= count + 1'b1;
		end
	end

	// Stays granted while valid holds
	assign rdy = valid && count_done;

endmodule

`default_nettype wire

//--- logic/banked_ram.sv
// Two-bank synchronous word RAM
//   bank picked by the top address bit
//   byte write mask, a set bit keeps that byte
//   registered read, one cycle latency
`timescale 1ns/100ps
`default_nettype none
`include "mem_if_config.svh"

module banked_ram (
	input  logic                 CLK,
	input  mem_if_pkg::mem_bus_t mem_bus,
	output mem_if_pkg::word_t    rdata
);
	import mem_if_pkg::*;

	localparam int BYTE_BITS  = `MEM_BITS / 2;
	localparam int INDEX_BITS = `MEM_ADDRESS_BITS - 1;

	word_t                 mem [2][`RAM_BANK_WORDS];
	logic                  bank_sel;
	logic [INDEX_BITS-1:0] word_idx;

	assign bank_sel = mem_bus.addr[INDEX_BITS];
	assign word_idx = mem_bus.addr[INDEX_BITS-1:0];

	always_ff @(posedge CLK) begin
		if (mem_bus.wr) begin
			// Mask bit 0 guards the low byte
			if (!mem_bus.wr_mask[0]) begin
				mem[bank_sel][word_idx][BYTE_BITS-1:0] <= mem_bus.wdata[BYTE_BITS-1:0];
			end
			// Mask bit 1 guards the high byte
			if (!mem_bus.wr_mask[1]) begin
				mem[bank_sel][word_idx][`MEM_BITS-1:BYTE_BITS] <=
					mem_bus.wdata[`MEM_BITS-1:BYTE_BITS];
			end
		end
		// Old data on a same-cycle write
		rdata <= mem[bank_sel][word_idx];
	end

endmodule

`default_nettype wire

//--- logic/mem_subsystem_top.sv
// Memory subsystem top level
//   CPU memory interface
//   bank grant timer
//   two-bank RAM
`timescale 1ns/100ps
`default_nettype none
`include "mem_if_config.svh"

module mem_subsystem_top (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  mem_if_pkg::addr_t     instr_addr,
	input  logic                  instr_read_req,
	output mem_if_pkg::word_t     instr_data,
	output mem_if_pkg::addr_t     instr_addr_out,
	output logic                  instr_success,
	output logic                  instr_will_queue,
	input  mem_if_pkg::data_req_t data_req,
	output mem_if_pkg::word_t     data_rdata,
	output logic                  data_success,
	output logic                  data_was_requested,
	output logic [1:0]            data_wr_mask_out,
	input  logic                  halt,
	output logic                  bank_sw
);
	import mem_if_pkg::*;

	mem_bus_t mem_bus;
	word_t    mem_rdata;
	logic     valid;
	logic     rdy;

	cpu_memory_interface u_mem_if (
		.CLK                (CLK),
		.RSTb               (RSTb),
		.instr_addr         (instr_addr),
		.instr_read_req     (instr_read_req),
		.instr_data         (instr_data),
		.instr_addr_out     (instr_addr_out),
		.instr_success      (instr_success),
		.instr_will_queue   (instr_will_queue),
		.data_req           (data_req),
		.data_rdata         (data_rdata),
		.data_success       (data_success),
		.data_was_requested (data_was_requested),
		.data_wr_mask_out   (data_wr_mask_out),
		.halt               (halt),
		.bank_sw            (bank_sw),
		.mem_bus            (mem_bus),
		.mem_rdata          (mem_rdata),
		.valid              (valid),
		.rdy                (rdy)
	);

	// Grants the bank after a fixed delay
	bank_grant_timer #(
		.GRANT_CYCLES (`BANK_GRANT_CYCLES)
	) u_grant (
		.CLK   (CLK),
		.RSTb  (RSTb),
		.valid (valid),
		.rdy   (rdy)
	);

	banked_ram u_ram (
		.CLK     (CLK),
		.mem_bus (mem_bus),
		.rdata   (mem_rdata)
	);

endmodule

`default_nettype wire

//--- tb/tb_mem_subsystem.sv
// Directed testbench for the memory subsystem
//   reset, write/read, byte mask merge, data over instruction priority
//   bank alternation and LCG random traffic
//   reference memory model kept as an associative array
`timescale 1ns/100ps
`default_nettype none
`include "mem_if_config.svh"

module tb_mem_subsystem;
	import mem_if_pkg::*;

	localparam int TIMEOUT = 50;
	localparam int HALF = `MEM_BITS / 2;
	localparam int QUIET_CYCLES = 4;

	logic       CLK;
	logic       RSTb;
	addr_t      instr_addr;
	logic       instr_read_req;
	word_t      instr_data;
	addr_t      instr_addr_out;
	logic       instr_success;
	logic       instr_will_queue;
	data_req_t  data_req;
	word_t      data_rdata;
	logic       data_success;
	logic       data_was_requested;
	logic [1:0] data_wr_mask_out;
	logic       halt;
	logic       bank_sw;

	// Expected memory contents, only written words
	word_t       ref_mem [addr_t];
	int unsigned lcg_state;
	int          error_count;
	int          tests_passed;
	int          tests_failed;
	int          test_start_errors;
	int          switch_count;
	int          queue_count;
	string       test_name;

	mem_subsystem_top uut (
		.CLK                (CLK),
		.RSTb               (RSTb),
		.instr_addr         (instr_addr),
		.instr_read_req     (instr_read_req),
		.instr_data         (instr_data),
		.instr_addr_out     (instr_addr_out),
		.instr_success      (instr_success),
		.instr_will_queue   (instr_will_queue),
		.data_req           (data_req),
		.data_rdata         (data_rdata),
		.data_success       (data_success),
		.data_was_requested (data_was_requested),
		.data_wr_mask_out   (data_wr_mask_out),
		.halt               (halt),
		.bank_sw            (bank_sw)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// A set mask bit keeps the old byte, a clear bit takes the new one
	function automatic word_t merge_masked(word_t old_word, word_t new_word, logic [1:0] mask);
		word_t result;
		result = old_word;
		if (!mask[0]) begin
			result[HALF-1:0] = new_word[HALF-1:0];
		end
		if (!mask[1]) begin
			result[`MEM_BITS-1:HALF] = new_word[`MEM_BITS-1:HALF];
		end
		return result;
	endfunction

	task automatic report_mismatch(string what, word_t expected, word_t actual);
		$display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
		error_count++;
	endtask

	task automatic start_test(string name);
		test_name = name;
		test_start_errors = error_count;
	endtask

	task automatic close_test();
		if (error_count == test_start_errors) begin
			tests_passed++;
			$display("%s: passed", test_name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, error_count - test_start_errors);
		end
	endtask

	// Poll success at the falling edge, counting bank switches and queued fetches
	task automatic wait_success(input logic want_instr, output logic ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
			if (bank_sw) begin
				switch_count++;
			end
			if (instr_will_queue) begin
				queue_count++;
			end
			if (!want_instr && instr_success) begin
				$display("%s: instruction success came while a data request was pending",
					test_name);
				error_count++;
			end
			ok = want_instr ? instr_success : data_success;
		end
		if (!ok) begin
			$display("%s: timed out after %0d cycles waiting for %s success", test_name,
				TIMEOUT, want_instr ? "instruction" : "data");
			error_count++;
		end
	endtask

	// Wait until stage 2 empties and no bank switch is running
	task automatic drain_pipe();
		int quiet;
		int cycles;
		quiet = 0;
		cycles = 0;
		while (quiet < QUIET_CYCLES && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
			if (data_was_requested || instr_success || bank_sw) begin
				quiet = 0;
			end else begin
				quiet++;
			end
		end
		if (quiet < QUIET_CYCLES) begin
			$display("%s: pipeline still busy after %0d cycles", test_name, TIMEOUT);
			error_count++;
		end
	endtask

	task automatic write_word(addr_t addr, word_t wdata, logic [1:0] mask);
		data_req_t req;
		logic      ok;
		word_t     old_word;
		req = '0;
		req.addr = addr;
		req.wdata = wdata;
		req.wr_req = 1'b1;
		req.wr_mask = mask;
		@(posedge CLK);
		data_req <= req;
		wait_success(1'b0, ok);
		if (ok && data_wr_mask_out !== mask) begin
			report_mismatch("write mask", word_t'(mask), word_t'(data_wr_mask_out));
		end
		// Held until success, then released
		@(posedge CLK);
		data_req <= '0;
		drain_pipe();
		old_word = ref_mem.exists(addr) ? ref_mem[addr] : '0;
		ref_mem[addr] = merge_masked(old_word, wdata, mask);
	endtask

	task automatic read_and_check(addr_t addr);
		data_req_t req;
		logic      ok;
		req = '0;
		req.addr = addr;
		req.rd_req = 1'b1;
		@(posedge CLK);
		data_req <= req;
		wait_success(1'b0, ok);
		if (ok && data_rdata !== ref_mem[addr]) begin
			report_mismatch($sformatf("read %h", addr), ref_mem[addr], data_rdata);
		end
		if (ok && !data_was_requested) begin
			$display("%s: data_was_requested low during data success", test_name);
			error_count++;
		end
		@(posedge CLK);
		data_req <= '0;
		drain_pipe();
	endtask

	task automatic idle_after_reset();
		start_test("idle_after_reset");
		repeat (10) begin
			@(negedge CLK);
			if (data_success || instr_success || bank_sw || instr_will_queue) begin
				$display("%s: status output high with no request pending", test_name);
				error_count++;
			end
		end
		@(posedge CLK);
		halt <= 1'b0;
		close_test();
	endtask

	task automatic write_then_read();
		start_test("write_then_read");
		write_word(15'h0042, 16'hbeef, 2'b00);
		read_and_check(15'h0042);
		close_test();
	endtask

	task automatic masked_write_merge();
		start_test("masked_write_merge");
		write_word(15'h0210, 16'ha5c3, 2'b00);
		write_word(15'h0210, 16'h1e2d, 2'b01);
		read_and_check(15'h0210);
		write_word(15'h0210, 16'h9b7a, 2'b10);
		read_and_check(15'h0210);
		// Both bytes kept, word unchanged
		write_word(15'h0210, 16'h0000, 2'b11);
		read_and_check(15'h0210);
		close_test();
	endtask

	task automatic data_over_instr();
		data_req_t req;
		logic      ok;
		start_test("data_over_instr");
		req = '0;
		req.addr = 15'h0100;
		req.wdata = 16'h7f31;
		req.wr_req = 1'b1;
		@(posedge CLK);
		data_req <= req;
		instr_addr <= 15'h0042;
		instr_read_req <= 1'b1;
		wait_success(1'b0, ok);
		@(posedge CLK);
		data_req <= '0;
		ref_mem[req.addr] = req.wdata;
		queue_count = 0;
		wait_success(1'b1, ok);
		if (queue_count == 0) begin
			$display("%s: instr_will_queue never rose for the held fetch", test_name);
			error_count++;
		end
		if (ok && instr_addr_out !== 15'h0042) begin
			report_mismatch("instr_addr_out", word_t'(15'h0042), word_t'(instr_addr_out));
		end
		if (ok && instr_data !== ref_mem[15'h0042]) begin
			report_mismatch("instr_data", ref_mem[15'h0042], instr_data);
		end
		@(posedge CLK);
		instr_read_req <= 1'b0;
		drain_pipe();
		read_and_check(15'h0100);
		close_test();
	endtask

	task automatic bank_alternation();
		addr_t bank_1;
		start_test("bank_alternation");
		switch_count = 0;
		bank_1 = addr_t'(1) << (`MEM_ADDRESS_BITS - 1);
		for (int i = 0; i < 4; i++) begin
			write_word(addr_t'(15'h0300 + i), word_t'(16'h3c00 + i), 2'b00);
			write_word(bank_1 | addr_t'(15'h0300 + i), word_t'(16'hc300 + i), 2'b00);
		end
		for (int i = 0; i < 4; i++) begin
			read_and_check(addr_t'(15'h0300 + i));
			read_and_check(bank_1 | addr_t'(15'h0300 + i));
		end
		if (switch_count == 0) begin
			$display("%s: bank_sw never rose across bank changes", test_name);
			error_count++;
		end
		close_test();
	endtask

	task automatic random_traffic();
		addr_t addr_list[$];
		addr_t addr;
		start_test("random_traffic");
		for (int i = 0; i < 20; i++) begin
			// Upper LCG bits, the low ones repeat quickly
			addr = addr_t'(lcg_next() >> 12);
			addr_list.push_back(addr);
			write_word(addr, word_t'(lcg_next() >> 16), 2'b00);
		end
		foreach (addr_list[i]) begin
			read_and_check(addr_list[i]);
		end
		close_test();
	endtask

	initial begin
		RSTb = 1'b0;
		halt = 1'b1;
		instr_addr = '0;
		instr_read_req = 1'b0;
		data_req = '0;
		lcg_state = 32'd56472;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		switch_count = 0;
		queue_count = 0;
		test_name = "reset";
		repeat (2) @(posedge CLK);
		RSTb <= 1'b1;
		idle_after_reset();
		write_then_read();
		masked_write_merge();
		data_over_instr();
		bank_alternation();
		random_traffic();
		$display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
